/* common/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// vector register and scalar operand widths
`define VLEN 128
`define XLEN 32

// element widths
`define BYTE_WIDTH 8
`define HWORD_WIDTH 16
`define WORD_WIDTH 32

// bytes per vector register, also the mask bits per micro-op
`define VLENB (`VLEN/`BYTE_WIDTH)

// reorder buffer tag
`define ROB_TAG_WIDTH 3

// micro-op index within a register group
`define UOP_INDEX_WIDTH 2

`endif

/* common/alu_pkg.sv */
`default_nettype none

`include "alu_settings.svh"

package alu_pkg;

  // operand form
  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100
  } funct3_e;

  // arithmetic funct6, RVV encodings
  typedef enum logic [5:0] {
    VMINU      = 6'b000100,
    VMIN       = 6'b000101,
    VMAXU      = 6'b000110,
    VMAX       = 6'b000111,
    VXUNARY0   = 6'b010010,
    VMERGE_VMV = 6'b010111
  } funct6_e;

  // vs1 field under VXUNARY0
  typedef enum logic [4:0] {
    VZEXT_VF4 = 5'b00100,
    VSEXT_VF4 = 5'b00101,
    VZEXT_VF2 = 5'b00110,
    VSEXT_VF2 = 5'b00111
  } ext_code_e;

  typedef enum logic [1:0] {
    EEW8  = 2'b00,
    EEW16 = 2'b01,
    EEW32 = 2'b10
  } eew_e;

  // low two bits of the min/max codes line up with funct6[1:0]
  typedef enum logic [2:0] {
    OP_MINU  = 3'd0,
    OP_MIN   = 3'd1,
    OP_MAXU  = 3'd2,
    OP_MAX   = 3'd3,
    OP_MOVE  = 3'd4,
    OP_MERGE = 3'd5,
    OP_ZEXT  = 3'd6,
    OP_SEXT  = 3'd7
  } alu_op_e;

  // one vector register seen as bytes, halfwords or words
  typedef union packed {
    logic [`VLENB-1:0][`BYTE_WIDTH-1:0]               b;
    logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0]  h;
    logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]    w;
  } vreg_u;

endpackage

`default_nettype wire

/* common/alu_stage_if.sv */
`default_nettype none

`include "alu_settings.svh"

interface alu_stage_if;
  import alu_pkg::*;

  logic                       valid;
  logic [`ROB_TAG_WIDTH-1:0]  rob_entry;
  alu_op_e                    op;
  eew_e                       eew;
  vreg_u                      src1;
  vreg_u                      src2;
  // one bit per element, merge only
  logic [`VLENB-1:0]          mask;

  modport source (
    output valid, rob_entry, op, eew, src1, src2, mask
  );

  modport sink (
    input valid, rob_entry, op, eew, src1, src2, mask
  );

endinterface

`default_nettype wire

/* execute/alu_lane_minmax.sv */
`default_nettype none

module alu_lane_minmax #(
  parameter int elem_width = 8
) (
  input  logic [elem_width-1:0]  a,
  input  logic [elem_width-1:0]  b,
  input  logic                   is_signed,
  input  logic                   take_max,
  output logic [elem_width-1:0]  y
);

  logic signed [elem_width:0]  a_ext;
  logic signed [elem_width:0]  b_ext;
  logic                        a_lt_b;

  // one extra bit lets a single signed compare cover both cases
  assign a_ext = {is_signed & a[elem_width-1], a};
  assign b_ext = {is_signed & b[elem_width-1], b};

  assign a_lt_b = a_ext < b_ext;

  // min keeps a when smaller, max keeps b then
  assign y = (a_lt_b ^ take_max) ? a : b;

endmodule

`default_nettype wire

/* decode/alu_uop_decode.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_uop_decode (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         uop_valid,
  input  logic [`ROB_TAG_WIDTH-1:0]    rob_entry,
  input  alu_pkg::funct3_e             funct3,
  input  alu_pkg::funct6_e             funct6,
  input  logic [4:0]                   vs1_index,
  input  logic                         vm,
  input  alu_pkg::eew_e                vd_eew,
  input  alu_pkg::eew_e                vs2_eew,
  input  logic [`UOP_INDEX_WIDTH-1:0]  uop_index,
  input  logic [`VLEN-1:0]             v0_data,
  input  logic                         v0_valid,
  input  logic [`VLEN-1:0]             vs1_data,
  input  logic                         vs1_valid,
  input  logic [`VLEN-1:0]             vs2_data,
  input  logic                         vs2_valid,
  input  logic [`XLEN-1:0]             rs1_data,
  input  logic                         rs1_valid,
  alu_stage_if.source                  stage
);
  import alu_pkg::*;

  alu_op_e              op_d;
  logic                 known_op;
  logic                 ext_vf4;
  logic                 is_ext;
  logic                 src1_ok;
  logic                 operands_ok;
  eew_e                 eew_d;
  logic [`VLEN-1:0]     rs1_rep;
  vreg_u                src1_d;
  vreg_u                src2_d;
  logic [`VLENB-1:0]    mask_d;
  logic [`VLEN/4-1:0]   ext_quarter;
  logic [`VLEN/2-1:0]   ext_half;
  logic [`VLEN/2-1:0]   ext_quarter_wide;

  always_comb begin
    op_d     = OP_MOVE;
    known_op = 1'b0;
    case (funct3)
      OPIVV, OPIVX, OPIVI: begin
        case (funct6)
          VMINU, VMIN, VMAXU, VMAX: begin
            op_d     = alu_op_e'({1'b0, funct6[1:0]});
            // no immediate form of min/max
            known_op = (funct3 != OPIVI);
          end
          VMERGE_VMV: begin
            op_d     = vm ? OP_MOVE : OP_MERGE;
            known_op = 1'b1;
          end
          default: ;
        endcase
      end
      OPMVV: begin
        if (funct6 == VXUNARY0) begin
          case (vs1_index)
            VZEXT_VF2, VZEXT_VF4: begin
              op_d     = OP_ZEXT;
              known_op = 1'b1;
            end
            VSEXT_VF2, VSEXT_VF4: begin
              op_d     = OP_SEXT;
              known_op = 1'b1;
            end
            default: ;
          endcase
        end
      end
      default: ;
    endcase
  end

  assign is_ext  = (op_d == OP_ZEXT) || (op_d == OP_SEXT);
  assign ext_vf4 = (vs1_index == VZEXT_VF4) || (vs1_index == VSEXT_VF4);
  assign src1_ok = (funct3 == OPIVV) ? vs1_valid : rs1_valid;

  // operand valids required by each form
  always_comb begin
    case (op_d)
      OP_MOVE:  operands_ok = src1_ok;
      OP_MERGE: operands_ok = src1_ok && vs2_valid && v0_valid;
      OP_ZEXT, OP_SEXT: begin
        operands_ok = !vs1_valid && vs2_valid &&
                      (ext_vf4 ? (vs2_eew == EEW8) :
                                 ((vs2_eew == EEW8) || (vs2_eew == EEW16)));
      end
      default:  operands_ok = src1_ok && vs2_valid;
    endcase
  end

  // execute only doubles, so vf4 leaves here already widened to halfwords
  always_comb begin
    eew_d = vs2_eew;
    if (op_d == OP_MOVE) begin
      eew_d = vd_eew;
    end else if (is_ext && ext_vf4) begin
      eew_d = EEW16;
    end
  end

  // scalar splat at the operation width
  always_comb begin
    case (eew_d)
      EEW8:    rs1_rep = {(`VLEN/`BYTE_WIDTH){rs1_data[`BYTE_WIDTH-1:0]}};
      EEW16:   rs1_rep = {(`VLEN/`HWORD_WIDTH){rs1_data[`HWORD_WIDTH-1:0]}};
      default: rs1_rep = {(`VLEN/`WORD_WIDTH){rs1_data[`WORD_WIDTH-1:0]}};
    endcase
  end

  assign src1_d = (funct3 == OPIVV) ? vs1_data : rs1_rep;

  assign ext_quarter = vs2_data[uop_index*(`VLEN/4) +: `VLEN/4];
  assign ext_half    = vs2_data[uop_index[0]*(`VLEN/2) +: `VLEN/2];

  always_comb begin
    for (int i = 0; i < (`VLEN/4)/`BYTE_WIDTH; i++) begin
      ext_quarter_wide[i*`HWORD_WIDTH +: `HWORD_WIDTH] =
        {{`BYTE_WIDTH{(op_d == OP_SEXT) & ext_quarter[i*`BYTE_WIDTH+`BYTE_WIDTH-1]}},
         ext_quarter[i*`BYTE_WIDTH +: `BYTE_WIDTH]};
    end
  end

  always_comb begin
    if (is_ext) begin
      src2_d = ext_vf4 ? {2{ext_quarter_wide}} : {2{ext_half}};
    end else begin
      src2_d = vs2_data;
    end
  end

  // v0 slice for this micro-op
  always_comb begin
    case (vs2_eew)
      EEW8:  mask_d = v0_data[uop_index*`VLENB +: `VLENB];
      EEW16: mask_d = {{(`VLENB/2){1'b0}}, v0_data[uop_index*(`VLENB/2) +: `VLENB/2]};
      default: begin
        mask_d = {{(`VLENB*3/4){1'b0}}, v0_data[uop_index*(`VLENB/4) +: `VLENB/4]};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage.valid <= 1'b0;
    end else begin
      stage.valid <= uop_valid && known_op && operands_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (uop_valid) begin
      stage.rob_entry <= rob_entry;
      stage.op        <= op_d;
      stage.eew       <= eew_d;
      stage.src1      <= src1_d;
      stage.src2      <= src2_d;
      stage.mask      <= mask_d;
    end
  end

  stage_valid_after_reset: assert property (@(posedge clk) !rst_n |=> !stage.valid)
    else $error("decode valid high right after reset");

endmodule

`default_nettype wire

/* execute/alu_execute.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_execute (
  input  logic                       clk,
  input  logic                       rst_n,
  alu_stage_if.sink                  stage,
  output logic                       result_valid,
  output logic [`ROB_TAG_WIDTH-1:0]  result_rob_entry,
  output logic [`VLEN-1:0]           result_data
);
  import alu_pkg::*;

  logic                                             is_signed;
  logic                                             take_max;
  logic [`VLENB-1:0][`BYTE_WIDTH-1:0]               mm8;
  logic [`VLEN/`HWORD_WIDTH-1:0][`HWORD_WIDTH-1:0]  mm16;
  logic [`VLEN/`WORD_WIDTH-1:0][`WORD_WIDTH-1:0]    mm32;
  logic [`VLEN-1:0]                                 minmax_res;
  vreg_u                                            merge_res;
  vreg_u                                            ext_res;
  logic [`VLEN-1:0]                                 result_d;

  assign is_signed = (stage.op == OP_MIN) || (stage.op == OP_MAX);
  assign take_max  = (stage.op == OP_MAXU) || (stage.op == OP_MAX);

  // vs2 on a, vs1 or scalar on b
  generate
    for (genvar i = 0; i < `VLENB; i++) begin : g_byte
      alu_lane_minmax #(.elem_width(`BYTE_WIDTH)) lane_inst (
        .a(stage.src2.b[i]), .b(stage.src1.b[i]),
        .is_signed(is_signed), .take_max(take_max), .y(mm8[i])
      );
    end
    for (genvar i = 0; i < `VLEN/`HWORD_WIDTH; i++) begin : g_hword
      alu_lane_minmax #(.elem_width(`HWORD_WIDTH)) lane_inst (
        .a(stage.src2.h[i]), .b(stage.src1.h[i]),
        .is_signed(is_signed), .take_max(take_max), .y(mm16[i])
      );
    end
    for (genvar i = 0; i < `VLEN/`WORD_WIDTH; i++) begin : g_word
      alu_lane_minmax #(.elem_width(`WORD_WIDTH)) lane_inst (
        .a(stage.src2.w[i]), .b(stage.src1.w[i]),
        .is_signed(is_signed), .take_max(take_max), .y(mm32[i])
      );
    end
  endgenerate

  always_comb begin
    case (stage.eew)
      EEW8:    minmax_res = mm8;
      EEW16:   minmax_res = mm16;
      default: minmax_res = mm32;
    endcase
  end

  always_comb begin
    merge_res = stage.src2;
    case (stage.eew)
      EEW8: begin
        for (int i = 0; i < `VLENB; i++) begin
          if (stage.mask[i]) merge_res.b[i] = stage.src1.b[i];
        end
      end
      EEW16: begin
        for (int i = 0; i < `VLEN/`HWORD_WIDTH; i++) begin
          if (stage.mask[i]) merge_res.h[i] = stage.src1.h[i];
        end
      end
      default: begin
        for (int i = 0; i < `VLEN/`WORD_WIDTH; i++) begin
          if (stage.mask[i]) merge_res.w[i] = stage.src1.w[i];
        end
      end
    endcase
  end

  // source elements come from the low half of src2, output is twice eew
  always_comb begin
    ext_res = '0;
    if (stage.eew == EEW8) begin
      for (int i = 0; i < `VLEN/`HWORD_WIDTH; i++) begin
        ext_res.h[i] = {{`BYTE_WIDTH{(stage.op == OP_SEXT) & stage.src2.b[i][`BYTE_WIDTH-1]}},
                        stage.src2.b[i]};
      end
    end else begin
      for (int i = 0; i < `VLEN/`WORD_WIDTH; i++) begin
        ext_res.w[i] = {{`HWORD_WIDTH{(stage.op == OP_SEXT) & stage.src2.h[i][`HWORD_WIDTH-1]}},
                        stage.src2.h[i]};
      end
    end
  end

  always_comb begin
    case (stage.op)
      OP_MOVE:          result_d = stage.src1;
      OP_MERGE:         result_d = merge_res;
      OP_ZEXT, OP_SEXT: result_d = ext_res;
      default:          result_d = minmax_res;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= stage.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stage.valid) begin
      result_rob_entry <= stage.rob_entry;
      result_data      <= result_d;
    end
  end

  result_follows_stage: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid |-> $past(stage.valid))
    else $error("result without a decoded micro-op one cycle earlier");

endmodule

`default_nettype wire

/* source/alu_other_top.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_other_top (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         uop_valid,
  input  logic [`ROB_TAG_WIDTH-1:0]    rob_entry,
  input  alu_pkg::funct3_e             funct3,
  input  alu_pkg::funct6_e             funct6,
  input  logic [4:0]                   vs1_index,
  input  logic                         vm,
  input  alu_pkg::eew_e                vd_eew,
  input  alu_pkg::eew_e                vs2_eew,
  input  logic [`UOP_INDEX_WIDTH-1:0]  uop_index,
  input  logic [`VLEN-1:0]             v0_data,
  input  logic                         v0_valid,
  input  logic [`VLEN-1:0]             vs1_data,
  input  logic                         vs1_valid,
  input  logic [`VLEN-1:0]             vs2_data,
  input  logic                         vs2_valid,
  input  logic [`XLEN-1:0]             rs1_data,
  input  logic                         rs1_valid,
  output logic                         result_valid,
  output logic [`ROB_TAG_WIDTH-1:0]    result_rob_entry,
  output logic [`VLEN-1:0]             result_data
);

  // decoded micro-op between the two stages
  alu_stage_if stage_if ();

  alu_uop_decode alu_uop_decode_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop_valid (uop_valid),
    .rob_entry (rob_entry),
    .funct3    (funct3),
    .funct6    (funct6),
    .vs1_index (vs1_index),
    .vm        (vm),
    .vd_eew    (vd_eew),
    .vs2_eew   (vs2_eew),
    .uop_index (uop_index),
    .v0_data   (v0_data),
    .v0_valid  (v0_valid),
    .vs1_data  (vs1_data),
    .vs1_valid (vs1_valid),
    .vs2_data  (vs2_data),
    .vs2_valid (vs2_valid),
    .rs1_data  (rs1_data),
    .rs1_valid (rs1_valid),
    .stage     (stage_if)
  );

  alu_execute alu_execute_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .stage            (stage_if),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

endmodule

`default_nettype wire

/* verification/alu_ref_pkg.sv */
`default_nettype none

`include "alu_settings.svh"

package alu_ref_pkg;

  typedef logic [`VLEN-1:0] vec_t;

  // element i of width w, zero extended
  function automatic longint elem(input vec_t v, input int w, input int i);
    vec_t t;
    t = (v >> (i * w)) & ((vec_t'(1) << w) - 1);
    return longint'(t[63:0]);
  endfunction

  function automatic longint as_signed(input longint x, input int w);
    return x[w-1] ? x - (longint'(1) << w) : x;
  endfunction

  // writes the low w bits of x into element i
  function automatic vec_t place(input vec_t r, input longint x, input int w, input int i);
    vec_t mask;
    mask = (vec_t'(1) << w) - 1;
    return r | ((vec_t'(x) & mask) << (i * w));
  endfunction

  function automatic vec_t ref_splat(input logic [`XLEN-1:0] x, input int w);
    vec_t r;
    r = '0;
    for (int i = 0; i < `VLEN / w; i++) begin
      r = place(r, longint'(x), w, i);
    end
    return r;
  endfunction

  function automatic vec_t ref_minmax(input vec_t a, input vec_t b, input int w,
                                      input bit sgn, input bit mx);
    vec_t   r;
    longint ea;
    longint eb;
    longint pick;
    r = '0;
    for (int i = 0; i < `VLEN / w; i++) begin
      ea = elem(a, w, i);
      eb = elem(b, w, i);
      if (sgn) begin
        ea = as_signed(ea, w);
        eb = as_signed(eb, w);
      end
      if (mx) pick = (ea > eb) ? ea : eb;
      else pick = (ea < eb) ? ea : eb;
      r = place(r, pick, w, i);
    end
    return r;
  endfunction

  // mask bit i of this micro-op sits at v0[idx * elements + i]
  function automatic vec_t ref_merge(input vec_t src1, input vec_t vs2, input vec_t v0,
                                     input int idx, input int w);
    vec_t r;
    int   n;
    r = '0;
    n = `VLEN / w;
    for (int i = 0; i < n; i++) begin
      r = place(r, v0[idx * n + i] ? elem(src1, w, i) : elem(vs2, w, i), w, i);
    end
    return r;
  endfunction

  function automatic vec_t ref_extend(input vec_t vs2, input int idx, input int factor,
                                      input int sw, input bit sgn);
    vec_t   r;
    longint x;
    int     dw;
    int     n;
    int     base;
    r = '0;
    dw = sw * factor;
    n = `VLEN / dw;
    base = (idx % factor) * n;
    for (int i = 0; i < n; i++) begin
      x = elem(vs2, sw, base + i);
      if (sgn) x = as_signed(x, sw);
      r = place(r, x, dw, i);
    end
    return r;
  endfunction

endpackage

`default_nettype wire

/* verification/alu_other_tb.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_other_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import alu_pkg::*;
  import alu_ref_pkg::*;

  localparam int CLK_PERIOD = 40;
  // reset 8, min/max 50, move/merge 47, extend 26, back to back 10, drops 14, tail 2
  localparam int TOTAL_STEPS = 8 + 50 + 47 + 26 + 10 + 14 + 2;

  typedef struct packed {
    logic                         valid;
    logic [`ROB_TAG_WIDTH-1:0]    rob;
    funct3_e                      funct3;
    funct6_e                      funct6;
    logic [4:0]                   vs1_index;
    logic                         vm;
    eew_e                         vd_eew;
    eew_e                         vs2_eew;
    logic [`UOP_INDEX_WIDTH-1:0]  uop_index;
    logic [`VLEN-1:0]             v0;
    logic                         v0_valid;
    logic [`VLEN-1:0]             vs1;
    logic                         vs1_valid;
    logic [`VLEN-1:0]             vs2;
    logic                         vs2_valid;
    logic [`XLEN-1:0]             rs1;
    logic                         rs1_valid;
  } uop_t;

  typedef struct packed {
    logic                       valid;
    logic [`ROB_TAG_WIDTH-1:0]  rob;
    logic [`VLEN-1:0]           data;
  } expect_t;

  logic                       clk;
  logic                       rst_n;
  uop_t                       drv;
  logic                       result_valid;
  logic [`ROB_TAG_WIDTH-1:0]  result_rob_entry;
  logic [`VLEN-1:0]           result_data;
  expect_t                    exp_q[$];
  integer                     seed;
  int                         errors;
  int                         checks;
  int                         tests_run;
  int                         tests_failed;
  int                         test_err_start;

  alu_other_top alu_other_top_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .uop_valid        (drv.valid),
    .rob_entry        (drv.rob),
    .funct3           (drv.funct3),
    .funct6           (drv.funct6),
    .vs1_index        (drv.vs1_index),
    .vm               (drv.vm),
    .vd_eew           (drv.vd_eew),
    .vs2_eew          (drv.vs2_eew),
    .uop_index        (drv.uop_index),
    .v0_data          (drv.v0),
    .v0_valid         (drv.v0_valid),
    .vs1_data         (drv.vs1),
    .vs1_valid        (drv.vs1_valid),
    .vs2_data         (drv.vs2),
    .vs2_valid        (drv.vs2_valid),
    .rs1_data         (drv.rs1),
    .rs1_valid        (drv.rs1_valid),
    .result_valid     (result_valid),
    .result_rob_entry (result_rob_entry),
    .result_data      (result_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((TOTAL_STEPS + 20) * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  function automatic int eew_bits(input eew_e e);
    case (e)
      EEW8:    return 8;
      EEW16:   return 16;
      default: return 32;
    endcase
  endfunction

  function automatic funct3_e form_of(input int f);
    if (f == 0) return OPIVV;
    if (f == 1) return OPIVX;
    return OPIVI;
  endfunction

  function automatic vec_t rand_vreg();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // every operand present, random data
  function automatic uop_t random_uop();
    uop_t u;
    u = '0;
    u.valid = 1'b1;
    u.rob = $random(seed);
    u.uop_index = $random(seed);
    u.v0 = rand_vreg();
    u.vs1 = rand_vreg();
    u.vs2 = rand_vreg();
    u.rs1 = $random(seed);
    u.v0_valid = 1'b1;
    u.vs1_valid = 1'b1;
    u.vs2_valid = 1'b1;
    u.rs1_valid = 1'b1;
    u.vm = 1'b1;
    return u;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("** Error @ %0t ns: %s", $time, msg);
  endtask

  task automatic check_result();
    expect_t e;
    e = exp_q.pop_front();
    checks++;
    valid_check: assert (result_valid === e.valid)
      else report_error($sformatf("result_valid is %b, expected %b", result_valid, e.valid));
    if (e.valid) begin
      rob_check: assert (result_rob_entry === e.rob)
        else report_error($sformatf("rob entry is %0d, expected %0d", result_rob_entry, e.rob));
      data_check: assert (result_data === e.data)
        else report_error($sformatf("result_data is %h, expected %h", result_data, e.data));
    end
  endtask

  // outputs at this falling edge belong to the micro-op driven two edges back
  task automatic step(input uop_t u, input logic ev, input vec_t ed);
    expect_t e;
    @(negedge clk);
    if (exp_q.size() == 2) begin
      check_result();
    end
    drv = u;
    e.valid = ev;
    e.rob = u.rob;
    e.data = ed;
    exp_q.push_back(e);
  endtask

  task automatic start_test();
    test_err_start = errors;
  endtask

  task automatic end_test(input string name);
    repeat (2) step('0, 1'b0, '0);
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail with %0d errors", tests_run, name, errors - test_err_start);
    end
  endtask

  initial begin
    uop_t u;
    vec_t ed;
    int   w;
    int   f;
    seed = 32217;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    drv = '0;

    start_test();
    // a legal micro-op sampled under reset gives no result
    u = random_uop();
    u.funct6 = VMERGE_VMV;
    u.funct3 = OPIVV;
    step(u, 1'b0, '0);
    step('0, 1'b0, '0);
    rst_n = 1'b1;
    repeat (3) step('0, 1'b0, '0);
    u = random_uop();
    u.funct6 = VMERGE_VMV;
    u.funct3 = OPIVX;
    u.vd_eew = EEW32;
    step(u, 1'b1, ref_splat(u.rs1, 32));
    end_test("reset");

    start_test();
    for (int op = 0; op < 4; op++) begin
      for (int form = 0; form < 2; form++) begin
        for (int e = 0; e < 3; e++) begin
          for (int rep = 0; rep < 2; rep++) begin
            u = random_uop();
            // min/max sit on consecutive codes, bit 0 signed and bit 1 max
            u.funct6 = funct6_e'(VMINU + op);
            u.funct3 = form ? OPIVX : OPIVV;
            u.vs2_eew = eew_e'(e);
            w = eew_bits(u.vs2_eew);
            ed = ref_minmax(u.vs2, form ? ref_splat(u.rs1, w) : u.vs1, w, op[0], op[1]);
            step(u, 1'b1, ed);
          end
        end
      end
    end
    end_test("min/max");

    start_test();
    for (int fm = 0; fm < 3; fm++) begin
      for (int e = 0; e < 3; e++) begin
        u = random_uop();
        u.funct6 = VMERGE_VMV;
        u.funct3 = form_of(fm);
        u.vd_eew = eew_e'(e);
        u.vs2_eew = eew_e'((e + 1) % 3);
        // a move reads neither vs2 nor v0
        u.vs2_valid = 1'b0;
        u.v0_valid = 1'b0;
        ed = (fm == 0) ? u.vs1 : ref_splat(u.rs1, eew_bits(u.vd_eew));
        step(u, 1'b1, ed);
      end
    end
    for (int fm = 0; fm < 3; fm++) begin
      for (int e = 0; e < 3; e++) begin
        for (int idx = 0; idx < 4; idx++) begin
          u = random_uop();
          u.funct6 = VMERGE_VMV;
          u.funct3 = form_of(fm);
          u.vm = 1'b0;
          u.vs2_eew = eew_e'(e);
          u.uop_index = idx;
          w = eew_bits(u.vs2_eew);
          ed = ref_merge((fm == 0) ? u.vs1 : ref_splat(u.rs1, w), u.vs2, u.v0, idx, w);
          step(u, 1'b1, ed);
        end
      end
    end
    end_test("move and merge");

    start_test();
    for (int s = 0; s < 2; s++) begin
      // k is vf2 from bytes, vf2 from halfwords, vf4 from bytes
      for (int k = 0; k < 3; k++) begin
        for (int idx = 0; idx < 4; idx++) begin
          u = random_uop();
          u.funct3 = OPMVV;
          u.funct6 = VXUNARY0;
          u.vs1_valid = 1'b0;
          u.uop_index = idx;
          u.vs2_eew = (k == 1) ? EEW16 : EEW8;
          f = (k == 2) ? 4 : 2;
          if (f == 4) u.vs1_index = s ? VSEXT_VF4 : VZEXT_VF4;
          else u.vs1_index = s ? VSEXT_VF2 : VZEXT_VF2;
          ed = ref_extend(u.vs2, idx, f, eew_bits(u.vs2_eew), s[0]);
          step(u, 1'b1, ed);
        end
      end
    end
    end_test("extension");

    start_test();
    for (int i = 0; i < 8; i++) begin
      u = random_uop();
      u.rob = i;
      u.funct6 = funct6_e'(VMINU + i % 4);
      u.funct3 = OPIVV;
      u.vs2_eew = eew_e'(i % 3);
      w = eew_bits(u.vs2_eew);
      step(u, 1'b1, ref_minmax(u.vs2, u.vs1, w, i[0], i[1]));
    end
    end_test("back to back");

    start_test();
    for (int i = 0; i < 6; i++) begin
      u = random_uop();
      u.funct6 = VMAX;
      u.funct3 = OPIVX;
      u.vs2_eew = EEW16;
      step(u, 1'b1, ref_minmax(u.vs2, ref_splat(u.rs1, 16), 16, 1'b1, 1'b1));
      u = random_uop();
      u.funct6 = VMIN;
      case (i)
        0: u.vs1_valid = 1'b0;
        1: begin
          u.funct3 = OPIVX;
          u.rs1_valid = 1'b0;
        end
        2: begin
          u.funct6 = VMERGE_VMV;
          u.vm = 1'b0;
          u.v0_valid = 1'b0;
        end
        3: begin
          u.funct3 = OPMVV;
          u.funct6 = VXUNARY0;
          u.vs1_index = VZEXT_VF2;
        end
        4: begin
          u.funct3 = OPMVV;
          u.funct6 = VXUNARY0;
          u.vs1_index = VSEXT_VF4;
          u.vs1_valid = 1'b0;
          u.vs2_eew = EEW16;
        end
        // no immediate form of min
        default: u.funct3 = OPIVI;
      endcase
      step(u, 1'b0, '0);
    end
    end_test("dropped micro-ops");

    repeat (2) step('0, 1'b0, '0);
    $display("tests run: %0d, tests failed: %0d, checks: %0d, errors: %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+common
common/alu_pkg.sv
common/alu_stage_if.sv
execute/alu_lane_minmax.sv
decode/alu_uop_decode.sv
execute/alu_execute.sv
source/alu_other_top.sv
verification/alu_ref_pkg.sv
verification/alu_other_tb.sv
